//--- vlog.f
design/imuldiv_msg_pkg.sv
design/imuldiv_ctrl_pkg.sv
design/imuldiv_operand_prep.sv
design/imuldiv_mul_dpath.sv
design/imuldiv_div_dpath.sv
design/imuldiv_ctrl.sv
design/imuldiv_result_fixup.sv
design/imuldiv_iterative.sv
tests/imuldiv_tb.sv

//--- Bender.yml
package:
  name: imuldiv

sources:
  - design/imuldiv_msg_pkg.sv
  - design/imuldiv_ctrl_pkg.sv
  - design/imuldiv_operand_prep.sv
  - design/imuldiv_mul_dpath.sv
  - design/imuldiv_div_dpath.sv
  - design/imuldiv_ctrl.sv
  - design/imuldiv_result_fixup.sv
  - design/imuldiv_iterative.sv
  - target: test
    files:
      - tests/imuldiv_tb.sv

//--- tests/imuldiv_tb.sv
// --------------------------------------------------
// testbench for the iterative multiply/divide unit
// stimulus, reference model and assertion checks
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_tb
  import imuldiv_msg_pkg::*;
();

  // corner pairs per op, random per op, zero divisors
  localparam int num_corner = 4 * 4 * 4;
  localparam int num_random = 4 * 40;
  localparam int num_zero   = 2 * 4;
  localparam int num_txn    = num_corner + num_random + num_zero;
  localparam int reset_cycles = 10;

  logic            clk;
  logic            reset;
  imuldiv_req_t    req;
  logic            req_val;
  logic            req_rdy;
  imuldiv_result_u resp;
  logic            resp_val;
  logic            resp_rdy;

  // monitor state
  logic            in_flight;
  int              edges_since;
  int              resp_count;
  imuldiv_result_u expected;
  logic            hold_q;
  imuldiv_result_u resp_hold;

  logic [31:0] corners [4] = '{32'h0000_0000, 32'h0000_0001, 32'hffff_ffff, 32'h8000_0000};

  imuldiv_iterative UUT (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------
  // reference model and failure report
  // --------------------------------------------------

  task automatic stop_on_error(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1);
  endtask

  // wide arithmetic, truncated to the response word
  function automatic imuldiv_result_u expected_result(input imuldiv_req_t r);
    logic signed [63:0] sa;
    logic signed [63:0] sb;
    logic        [63:0] ua;
    logic        [63:0] ub;
    imuldiv_result_u    e;
    sa = $signed(r.a);
    sb = $signed(r.b);
    ua = {32'd0, r.a};
    ub = {32'd0, r.b};
    e  = '0;
    case (r.op)
      op_mul:  e.product = sa * sb;
      op_mulu: e.product = ua * ub;
      default: begin
        if (r.b == 32'd0) begin
          // divide by zero: all ones and the dividend back
          e.divres.quotient  = '1;
          e.divres.remainder = r.a;
        end else if (r.op == op_div) begin
          // truncating division, most negative by -1 wraps here
          e.divres.quotient  = 32'(sa / sb);
          e.divres.remainder = 32'(sa % sb);
        end else begin
          e.divres.quotient  = 32'(ua / ub);
          e.divres.remainder = 32'(ua % ub);
        end
      end
    endcase
    return e;
  endfunction

  // --------------------------------------------------
  // assertion checks, sampled on the rising edge
  // --------------------------------------------------

  always @(posedge clk) begin
    if (!reset) begin
      if (in_flight) begin
        assert (!req_rdy) else stop_on_error(
          $sformatf("Error at %0t: req_rdy expected 0, got %0b", $time, req_rdy));
        // response shows up 33 edges after acceptance, not earlier
        assert (resp_val == (edges_since >= 33)) else stop_on_error(
          $sformatf("Error at %0t: resp_val expected %0b, got %0b",
                    $time, edges_since >= 33, resp_val));
      end else begin
        assert (req_rdy) else stop_on_error(
          $sformatf("Error at %0t: req_rdy expected 1, got %0b", $time, req_rdy));
        assert (!resp_val) else stop_on_error(
          $sformatf("Error at %0t: resp_val expected 0, got %0b", $time, resp_val));
      end
      // held response under back-pressure
      if (hold_q) begin
        assert (resp == resp_hold) else stop_on_error(
          $sformatf("Error at %0t: resp expected %h, got %h", $time, resp_hold, resp));
      end
      if (resp_val && resp_rdy) begin
        assert (resp == expected) else stop_on_error(
          $sformatf("Error at %0t: resp expected %h, got %h", $time, expected, resp));
        resp_count <= resp_count + 1;
        in_flight  <= 1'b0;
      end
      if (req_val && req_rdy) begin
        in_flight   <= 1'b1;
        edges_since <= 0;
        expected    <= expected_result(req);
      end else if (in_flight) begin
        edges_since <= edges_since + 1;
      end
      hold_q    <= resp_val && !resp_rdy;
      resp_hold <= resp;
    end
  end

  // --------------------------------------------------
  // stimulus, driven on falling edges
  // --------------------------------------------------

  // waits for acceptance, req_val may stay high into the next request
  task automatic send(input imuldiv_op_e op, input logic [31:0] a, input logic [31:0] b);
    req.op  = op;
    req.a   = a;
    req.b   = b;
    req_val = 1'b1;
    while (!req_rdy) begin
      @(negedge clk);
    end
    @(negedge clk);
    // occasional idle gap between requests
    if ($urandom % 4 == 0) begin
      req_val = 1'b0;
      @(negedge clk);
    end
  endtask

  // random stretches of resp_rdy low
  task automatic drive_backpressure();
    forever begin
      resp_rdy = ($urandom % 4) != 0;
      repeat (1 + $urandom % 4) @(negedge clk);
    end
  endtask

  initial begin
    void'($urandom(32'h2284d55f));
    reset      = 1'b1;
    req        = '0;
    req_val    = 1'b0;
    resp_rdy   = 1'b0;
    in_flight  = 1'b0;
    edges_since = 0;
    resp_count = 0;
    expected   = '0;
    hold_q     = 1'b0;
    resp_hold  = '0;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;
    fork
      drive_backpressure();
    join_none
    // corner operands for every opcode
    for (int o = 0; o < 4; o++) begin
      for (int i = 0; i < 4; i++) begin
        for (int j = 0; j < 4; j++) begin
          send(imuldiv_op_e'(o), corners[i], corners[j]);
        end
      end
    end
    // random operands, divisor narrowed to get varied quotients
    for (int o = 0; o < 4; o++) begin
      for (int k = 0; k < 40; k++) begin
        send(imuldiv_op_e'(o), $urandom, $urandom >> ($urandom % 32));
      end
    end
    for (int k = 0; k < 4; k++) begin
      send(op_div, $urandom, 32'd0);
      send(op_divu, $urandom, 32'd0);
    end
    req_val = 1'b0;
    wait (resp_count == num_txn);
    @(negedge clk);
    $display("No errors");
    $finish;
  end

  // watchdog sized from the transaction count
  initial begin
    repeat (num_txn * 40 + reset_cycles) @(posedge clk);
    stop_on_error("Timeout: watchdog expired before all responses were checked");
  end

endmodule

`default_nettype wire

//--- design/imuldiv_iterative.sv
// --------------------------------------------------
// iterative multiply/divide unit, top level
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_iterative
  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire imuldiv_req_t req,
  input  wire logic         req_val,
  output logic              req_rdy,
  output imuldiv_result_u   resp,
  output logic              resp_val,
  input  wire logic         resp_rdy
);

  dpath_ctrl_t ctrl;
  logic [31:0] mag_a;
  logic [31:0] mag_b;
  sign_info_t  sign;
  logic [63:0] product;
  logic [31:0] quotient;
  logic [31:0] remainder;

  imuldiv_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .ctrl     (ctrl)
  );

  imuldiv_operand_prep u_prep (
    .clk   (clk),
    .reset (reset),
    .ctrl  (ctrl),
    .req   (req),
    .mag_a (mag_a),
    .mag_b (mag_b),
    .sign  (sign)
  );

  // both loops run on every request, fixup picks one
  imuldiv_mul_dpath u_mul (
    .clk     (clk),
    .reset   (reset),
    .ctrl    (ctrl),
    .mag_a   (mag_a),
    .mag_b   (mag_b),
    .product (product)
  );

  imuldiv_div_dpath u_div (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .mag_a     (mag_a),
    .mag_b     (mag_b),
    .quotient  (quotient),
    .remainder (remainder)
  );

  imuldiv_result_fixup u_fixup (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .sign      (sign),
    .product   (product),
    .quotient  (quotient),
    .remainder (remainder),
    .resp      (resp)
  );

endmodule

`default_nettype wire

//--- design/imuldiv_result_fixup.sv
// --------------------------------------------------
// result select, sign correction and response reg
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_result_fixup
  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire dpath_ctrl_t ctrl,
  input  wire sign_info_t  sign,
  input  wire logic [63:0] product,
  input  wire logic [31:0] quotient,
  input  wire logic [31:0] remainder,
  output imuldiv_result_u  resp
);

  logic            is_div;
  imuldiv_result_u resp_d;

  always_comb begin
    is_div = (sign.op == op_div) || (sign.op == op_divu);
    if (is_div) begin
      // zero divisor always reports all ones, whatever the signs
      if (sign.div_zero) begin
        resp_d.divres.quotient = '1;
      end else begin
        resp_d.divres.quotient = sign.neg_quo ? (~quotient + 32'd1) : quotient;
      end
      resp_d.divres.remainder = sign.neg_rem ? (~remainder + 32'd1) : remainder;
    end else begin
      resp_d.product = sign.neg_prod ? (~product + 64'd1) : product;
    end
  end

  // response register, held through back-pressure
  always_ff @(posedge clk) begin
    if (reset) begin
      resp <= '0;
    end else if (ctrl.capture) begin
      resp <= resp_d;
    end
  end

endmodule

`default_nettype wire

//--- design/imuldiv_ctrl.sv
// --------------------------------------------------
// controller: handshakes, step counter and
// datapath enables
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_ctrl
  import imuldiv_ctrl_pkg::*;
(
  input  wire logic  clk,
  input  wire logic  reset,
  input  wire logic  req_val,
  output logic       req_rdy,
  output logic       resp_val,
  input  wire logic  resp_rdy,
  output dpath_ctrl_t ctrl
);

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  // counts the 32 calc cycles
  logic [4:0]  count_q;
  logic        last_step;

  assign last_step = (count_q == 5'd31);

  // --------------------------------------------------
  // next state
  // --------------------------------------------------

  always_comb begin
    state_d = state_q;
    case (state_q)
      idle: begin
        if (req_val) begin
          state_d = calc;
        end
      end
      calc: begin
        if (last_step) begin
          state_d = fix;
        end
      end
      // one cycle for sign correction and capture
      fix: begin
        state_d = done;
      end
      // hold the response until it is taken
      done: begin
        if (resp_rdy) begin
          state_d = idle;
        end
      end
      default: begin
        state_d = idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state_q <= idle;
      count_q <= 5'd0;
    end else begin
      state_q <= state_d;
      // counter wraps back to zero after the last step
      if (state_q == calc) begin
        count_q <= count_q + 5'd1;
      end
    end
  end

  // --------------------------------------------------
  // outputs, decoded from state
  // --------------------------------------------------

  always_comb begin
    req_rdy      = (state_q == idle);
    resp_val     = (state_q == done);
    // load only on the acceptance edge
    ctrl.load    = (state_q == idle) && req_val;
    ctrl.step    = (state_q == calc);
    ctrl.capture = (state_q == fix);
  end

endmodule

`default_nettype wire

//--- design/imuldiv_div_dpath.sv
// --------------------------------------------------
// restoring shift-subtract divider, 32 steps
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_div_dpath
  import imuldiv_ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire dpath_ctrl_t ctrl,
  input  wire logic [31:0] mag_a,
  input  wire logic [31:0] mag_b,
  output logic [31:0]      quotient,
  output logic [31:0]      remainder
);

  // remainder and quotient registers
  // quo_q starts as the dividend and fills with quotient bits from the right
  logic [31:0] rem_q;
  logic [31:0] quo_q;
  logic        init_q;

  logic [31:0] rem_src;
  logic [31:0] quo_src;
  // partial remainder with the next dividend bit shifted in
  logic [32:0] part_rem;
  logic [32:0] diff;
  logic        fits;

  always_comb begin
    rem_src  = init_q ? 32'd0 : rem_q;
    quo_src  = init_q ? mag_a : quo_q;
    part_rem = {rem_src, quo_src[31]};
    diff     = part_rem - {1'b0, mag_b};
    // bit 32 set means the subtraction went negative
    // zero divisor always fits, so quotient ends all ones and remainder = dividend
    fits     = !diff[32];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      init_q <= 1'b0;
    end else if (ctrl.load) begin
      init_q <= 1'b1;
    end else if (ctrl.step) begin
      init_q <= 1'b0;
    end
  end

  // restore by keeping the shifted value when the divisor does not fit
  always_ff @(posedge clk) begin
    if (ctrl.step) begin
      rem_q <= fits ? diff[31:0] : part_rem[31:0];
      quo_q <= {quo_src[30:0], fits};
    end
  end

  assign quotient  = quo_q;
  assign remainder = rem_q;

endmodule

`default_nettype wire

//--- design/imuldiv_mul_dpath.sv
// --------------------------------------------------
// shift-add multiplier over a 64-bit accumulator
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_mul_dpath
  import imuldiv_ctrl_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        reset,
  input  wire dpath_ctrl_t ctrl,
  input  wire logic [31:0] mag_a,
  input  wire logic [31:0] mag_b,
  output logic [63:0]      product
);

  // iteration registers
  logic [63:0] mcand_q;
  logic [31:0] mplier_q;
  logic [63:0] acc_q;
  // set by load, first step starts from the magnitudes
  logic        init_q;

  logic [63:0] mcand_src;
  logic [31:0] mplier_src;
  logic [63:0] acc_src;

  // first step reads the registered magnitudes instead of the loop
  always_comb begin
    mcand_src  = init_q ? {32'd0, mag_a} : mcand_q;
    mplier_src = init_q ? mag_b : mplier_q;
    acc_src    = init_q ? 64'd0 : acc_q;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      init_q <= 1'b0;
    end else if (ctrl.load) begin
      init_q <= 1'b1;
    end else if (ctrl.step) begin
      init_q <= 1'b0;
    end
  end

  // one partial product per step, lsb of the multiplier decides
  always_ff @(posedge clk) begin
    if (ctrl.step) begin
      acc_q    <= mplier_src[0] ? (acc_src + mcand_src) : acc_src;
      mcand_q  <= mcand_src << 1;
      mplier_q <= mplier_src >> 1;
    end
  end

  assign product = acc_q;

endmodule

`default_nettype wire

//--- design/imuldiv_operand_prep.sv
// --------------------------------------------------
// operand preparation: magnitude and sign capture
// --------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module imuldiv_operand_prep
  import imuldiv_msg_pkg::*;
  import imuldiv_ctrl_pkg::*;
(
  input  wire logic         clk,
  input  wire logic         reset,
  input  wire dpath_ctrl_t  ctrl,
  input  wire imuldiv_req_t req,
  output logic [31:0]       mag_a,
  output logic [31:0]       mag_b,
  output sign_info_t        sign
);

  logic       is_signed;
  logic       neg_a;
  logic       neg_b;
  logic       b_zero;
  sign_info_t sign_d;

  always_comb begin
    // only mul and div treat operands as two's complement
    is_signed = (req.op == op_mul) || (req.op == op_div);
    neg_a     = is_signed && req.a[31];
    neg_b     = is_signed && req.b[31];
    b_zero    = (req.b == 32'd0);

    sign_d.op       = req.op;
    // product and quotient negative when exactly one operand is
    sign_d.neg_prod = neg_a ^ neg_b;
    // zero divisor keeps the all ones quotient untouched
    sign_d.neg_quo  = (neg_a ^ neg_b) && !b_zero;
    // remainder follows the dividend
    sign_d.neg_rem  = neg_a;
    sign_d.div_zero = b_zero;
  end

  // magnitudes, most negative value maps onto 2^31 unsigned
  always_ff @(posedge clk) begin
    if (ctrl.load) begin
      mag_a <= neg_a ? (~req.a + 32'd1) : req.a;
      mag_b <= neg_b ? (~req.b + 32'd1) : req.b;
    end
  end

  // sign flags held until the next acceptance
  always_ff @(posedge clk) begin
    if (reset) begin
      sign <= '0;
    end else if (ctrl.load) begin
      sign <= sign_d;
    end
  end

endmodule

`default_nettype wire

//--- design/imuldiv_ctrl_pkg.sv
// --------------------------------------------------
// controller states, datapath control struct and
// operand sign information
// --------------------------------------------------

`default_nettype none

package imuldiv_ctrl_pkg;
  import imuldiv_msg_pkg::*;

  typedef enum logic [1:0] {
    idle = 2'd0,
    calc = 2'd1,
    fix  = 2'd2,
    done = 2'd3
  } ctrl_state_e;

  // broadcast from the controller to every datapath block
  typedef struct packed {
    logic load;
    logic step;
    logic capture;
  } dpath_ctrl_t;

  // sign rules recorded at acceptance, applied by the fixup
  typedef struct packed {
    imuldiv_op_e op;
    logic        neg_prod;
    logic        neg_quo;
    logic        neg_rem;
    logic        div_zero;
  } sign_info_t;

endpackage

`default_nettype wire

//--- design/imuldiv_msg_pkg.sv
// --------------------------------------------------
// opcode, request struct and response union types
// for the iterative multiply/divide unit ports
// --------------------------------------------------

`default_nettype none

package imuldiv_msg_pkg;

  // --------------------------------------------------
  // operation codes
  // --------------------------------------------------

  // signed ops take magnitudes at acceptance, unsigned ops pass through
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_mulu = 2'd1,
    op_div  = 2'd2,
    op_divu = 2'd3
  } imuldiv_op_e;

  // --------------------------------------------------
  // request and response words
  // --------------------------------------------------

  // a is multiplicand or dividend, b is multiplier or divisor
  typedef struct packed {
    imuldiv_op_e op;
    logic [31:0] a;
    logic [31:0] b;
  } imuldiv_req_t;

  // remainder sits in the upper half
  typedef struct packed {
    logic [31:0] remainder;
    logic [31:0] quotient;
  } imuldiv_divres_t;

  // one response word, read as a product or as quotient/remainder
  typedef union packed {
    logic [63:0]     product;
    imuldiv_divres_t divres;
  } imuldiv_result_u;

endpackage

`default_nettype wire
